/* hdl/e300_params.svh */
/*
 * Button interrupt path build constants
 */

`ifndef E300_PARAMS_SVH
`define E300_PARAMS_SVH

// ------------------------------------------------
// Event queue
// ------------------------------------------------

// Entries in the event queue, power of two
`define E300_EVENT_FIFO_DEPTH 8

// ------------------------------------------------
// Interrupt outputs
// ------------------------------------------------

// Interrupt pulse width in bus_clk cycles
`define E300_IRQ_STRETCH 8

// Wrapping event sequence number width
`define E300_SEQ_WIDTH 8

`endif

/* hdl/button_event_pkg.sv */
/*
 * Button event types
 * Kind of switch transition and the numbered event record
 */

`include "e300_params.svh"

package button_event_pkg;

  // Transition of the active low power switch
  typedef enum logic {
    EV_PRESS   = 1'b0,
    EV_RELEASE = 1'b1
  } event_kind_t;

  // One queued event, 9 bits with the default sequence width
  typedef struct packed {
    event_kind_t                kind;
    logic [`E300_SEQ_WIDTH-1:0] seq;
  } button_event_t;

endpackage

/* hdl/irq_pkg.sv */
/*
 * Interrupt output types
 * Interrupt line pair and stretcher status word
 */

`include "e300_params.svh"

package irq_pkg;

  // Same order as the processor interrupt bits, release above press
  typedef struct packed {
    logic release_irq;
    logic press_irq;
  } irq_vec_t;

  // Sequence number of the event being signalled
  // plus the sticky queue overflow flag
  typedef struct packed {
    logic [`E300_SEQ_WIDTH-1:0] seq;
    logic                       overflow;
  } irq_status_t;

endpackage

/* hdl/button_edge_detect.sv */
/*
 * Power switch edge detector
 * Finds press and release of the active low switch, emits numbered events
 */

`timescale 1ns/1ps

`include "e300_params.svh"

module button_edge_detect
  import button_event_pkg::*;
(
  input  logic          bus_clk,
  input  logic          bus_rst,
  input  logic          onswitch_db,
  output logic          event_valid,
  output button_event_t ev
);

  // Two previous switch samples, bit 1 is the older one
  logic [1:0] hist;

  logic press;
  logic release_edge;

  logic [`E300_SEQ_WIDTH-1:0] seq_cnt;

  // ------------------------------------------------
  // Edge recognition
  // ------------------------------------------------

  // Starts as released so a high switch after reset is quiet
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      hist <= 2'b11;
    end else begin
      hist <= {hist[0], onswitch_db};
    end
  end

  // Low now after two high samples
  assign press = ~onswitch_db & hist[0] & hist[1];

  // High now after two low samples
  assign release_edge = onswitch_db & ~hist[0] & ~hist[1];

  // ------------------------------------------------
  // Event output
  // ------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      event_valid <= 1'b0;
      seq_cnt     <= '0;
    end else begin
      event_valid <= press | release_edge;
      // Wraps at the sequence width
      if (press | release_edge) begin
        seq_cnt <= seq_cnt + 1'b1;
      end
    end
  end

  // Event payload captured on each recognized edge
  always_ff @(posedge bus_clk) begin
    if (press | release_edge) begin
      ev.kind <= press ? EV_PRESS : EV_RELEASE;
      ev.seq  <= seq_cnt;
    end
  end

endmodule

/* hdl/event_fifo.sv */
/*
 * Show-ahead event FIFO
 * Drops writes while full and latches a sticky overflow flag
 */

`timescale 1ns/1ps

module event_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 8
) (
  input  logic     bus_clk,
  input  logic     bus_rst,
  input  logic     wr,
  input  payload_t wr_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     overflow
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;

  logic full;
  logic wr_ok;
  logic rd_ok;

  assign full  = (count == (AW + 1)'(DEPTH));
  assign empty = (count == '0);

  // Full queue loses the incoming event
  assign wr_ok = wr & ~full;
  assign rd_ok = pop & ~empty;

  // Oldest entry always visible
  assign head = mem[rd_ptr];

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ------------------------------------------------
  // Pointers, occupancy and overflow
  // ------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // Power of two depth, pointers wrap by themselves
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // Sticky until reset
      if (wr & full) begin
        overflow <= 1'b1;
      end
    end
  end

  // Consumer must wait for data
  assert property (@(posedge bus_clk) disable iff (bus_rst)
    pop |-> !empty)
    else $error("pop while FIFO empty");

endmodule

/* hdl/irq_stretch.sv */
/*
 * Interrupt stretcher
 * Pops one event at a time and holds its interrupt line for a fixed width
 */

`timescale 1ns/1ps

`include "e300_params.svh"

module irq_stretch
  import button_event_pkg::*;
  import irq_pkg::*;
(
  input  logic          bus_clk,
  input  logic          bus_rst,
  input  button_event_t head,
  input  logic          empty,
  input  logic          overflow,
  output logic          pop,
  output irq_vec_t      irq,
  output irq_status_t   status
);

  localparam int CNT_W = ($clog2(`E300_IRQ_STRETCH) > 0) ? $clog2(`E300_IRQ_STRETCH) : 1;

  typedef enum logic {
    ST_IDLE,
    ST_ACTIVE
  } state_t;

  state_t state;

  logic [CNT_W-1:0]           cnt;
  logic [`E300_SEQ_WIDTH-1:0] seq_q;

  // Only pop while no pulse is running
  assign pop = (state == ST_IDLE) & ~empty;

  // ------------------------------------------------
  // Pulse FSM
  // ------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state <= ST_IDLE;
      cnt   <= '0;
      irq   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (pop) begin
            state           <= ST_ACTIVE;
            cnt             <= CNT_W'(`E300_IRQ_STRETCH - 1);
            irq.press_irq   <= (head.kind == EV_PRESS);
            irq.release_irq <= (head.kind == EV_RELEASE);
          end
        end
        ST_ACTIVE: begin
          if (cnt == '0) begin
            // Low for a cycle in idle before the next pop
            state <= ST_IDLE;
            irq   <= '0;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Sequence number of the event being signalled
  always_ff @(posedge bus_clk) begin
    if (pop) begin
      seq_q <= head.seq;
    end
  end

  assign status.seq      = seq_q;
  assign status.overflow = overflow;

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // Pulse ends after the stretch width and is followed by a low cycle
  assert property (@(posedge bus_clk) disable iff (bus_rst)
    (irq != '0) [*`E300_IRQ_STRETCH] |=> (irq == '0))
    else $error("interrupt pulse longer than stretch width");

endmodule

/* hdl/e300_button_irq.sv */
/*
 * Front-panel button interrupt path
 * Edge detector feeding an event queue drained by the interrupt stretcher
 */

`timescale 1ns/1ps

`include "e300_params.svh"

module e300_button_irq
  import button_event_pkg::*;
  import irq_pkg::*;
(
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  logic        onswitch_db,
  output irq_vec_t    irq,
  output irq_status_t status
);

  logic          event_valid;
  button_event_t ev;

  button_event_t head;
  logic          empty;
  logic          overflow;
  logic          pop;

  // Switch edges to numbered events
  button_edge_detect edge0 (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_db (onswitch_db),
    .event_valid (event_valid),
    .ev          (ev)
  );

  // Buffers events while a pulse is being stretched
  event_fifo #(
    .payload_t (button_event_t),
    .DEPTH     (`E300_EVENT_FIFO_DEPTH)
  ) fifo0 (
    .bus_clk  (bus_clk),
    .bus_rst  (bus_rst),
    .wr       (event_valid),
    .wr_data  (ev),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .overflow (overflow)
  );

  irq_stretch stretch0 (
    .bus_clk  (bus_clk),
    .bus_rst  (bus_rst),
    .head     (head),
    .empty    (empty),
    .overflow (overflow),
    .pop      (pop),
    .irq      (irq),
    .status   (status)
  );

endmodule

/* testbench/e300_button_irq_tb.sv */
/*
 * Testbench for the button interrupt path
 * Replays the switch trace and checks every stretched interrupt pulse
 */

`timescale 1ns/1ps

`include "e300_params.svh"

module e300_button_irq_tb
  import button_event_pkg::*;
  import irq_pkg::*;
();

  logic        bus_clk;
  logic        bus_rst;
  logic        onswitch_db;
  irq_vec_t    irq;
  irq_status_t status;

  // Trace contents
  logic        stim_level[$];
  int          stim_hold[$];
  int          exp_test[$];
  event_kind_t exp_kind[$];
  irq_status_t exp_status[$];

  int          limit_cycles;
  int          cycle_cnt = 0;
  int          seen = 0;
  int          width = 0;
  irq_vec_t    prev_irq = '0;
  irq_vec_t    exp_vec;

  e300_button_irq dut0 (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_db (onswitch_db),
    .irq         (irq),
    .status      (status)
  );

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  // ------------------------------------------------
  // Compare tasks
  // ------------------------------------------------

  task automatic stop_run(string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic string test_name(int id);
    case (id)
      2:       return "press_release";
      4:       return "glitch";
      default: return "burst_overflow";
    endcase
  endfunction

  task automatic check_irq(string name, irq_vec_t exp, irq_vec_t act);
    if (act !== exp) begin
      stop_run($sformatf("Fail %s: expected irq %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_status(string name, irq_status_t exp, irq_status_t act);
    if (act !== exp) begin
      stop_run($sformatf("Fail %s: expected seq %0d overflow %b actual seq %0d overflow %b",
                         name, exp.seq, exp.overflow, act.seq, act.overflow));
    end
  endtask

  task automatic check_width(string name, int exp, int act);
    if (act != exp) begin
      stop_run($sformatf("Fail %s: expected %0d cycles actual %0d", name, exp, act));
    end
  endtask

  // ------------------------------------------------
  // Trace reader
  // ------------------------------------------------

  // T expands into alternating levels starting from the opposite of the last one
  task automatic read_trace();
    int                 fd;
    int                 code;
    int                 want;
    int                 a;
    int                 b;
    int                 c;
    int                 d;
    logic [7:0]         tag;
    logic [8*128-1:0]   skip;
    logic               lvl;
    irq_status_t        st;
    fd = $fopen("testbench/button_irq_trace.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open the trace file");
    end
    lvl = 1'b1;
    while ($fscanf(fd, " %c", tag) == 1) begin
      if (tag == "#") begin
        want = 0;
        code = $fgets(skip, fd);
      end else if (tag == "S") begin
        want = 2;
        code = $fscanf(fd, " %d %d", a, b);
        lvl  = a[0];
        stim_level.push_back(lvl);
        stim_hold.push_back(b);
      end else if (tag == "T") begin
        want = 2;
        code = $fscanf(fd, " %d %d", a, b);
        repeat (a) begin
          lvl = ~lvl;
          stim_level.push_back(lvl);
          stim_hold.push_back(b);
        end
      end else if (tag == "E") begin
        want        = 4;
        code        = $fscanf(fd, " %d %d %d %d", a, b, c, d);
        st.seq      = c[`E300_SEQ_WIDTH-1:0];
        st.overflow = d[0];
        exp_test.push_back(a);
        exp_kind.push_back(event_kind_t'(b[0]));
        exp_status.push_back(st);
      end else begin
        stop_run("unknown line type in the trace file");
      end
      if (code < want) begin
        stop_run("malformed line in the trace file");
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------

  initial begin
    bus_rst     = 1'b1;
    onswitch_db = 1'b1;
    read_trace();
    limit_cycles = 100 + (`E300_IRQ_STRETCH + 1) * exp_kind.size();
    foreach (stim_hold[i]) begin
      limit_cycles += stim_hold[i];
    end

    repeat (2) @(posedge bus_clk);
    bus_rst <= 1'b0;
    @(negedge bus_clk);
    check_irq("reset_state", '0, irq);
    @(posedge bus_clk);

    foreach (stim_level[i]) begin
      onswitch_db <= stim_level[i];
      repeat (stim_hold[i]) @(posedge bus_clk);
    end

    // Drain whatever is still queued
    while (seen < exp_kind.size() || prev_irq != '0) begin
      @(posedge bus_clk);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  always @(posedge bus_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= limit_cycles) begin
      stop_run("timeout, the expected interrupt sequence did not complete");
    end
  end

  // ------------------------------------------------
  // Interrupt monitor
  // ------------------------------------------------

  // Falling edge sampling, outputs settled since the rising edge
  always @(negedge bus_clk) begin
    if (!bus_rst) begin
      if (irq != '0 && prev_irq == '0) begin
        if (seen >= exp_kind.size()) begin
          stop_run("an interrupt arrived beyond the expected sequence");
        end
        exp_vec.press_irq   = (exp_kind[seen] == EV_PRESS);
        exp_vec.release_irq = (exp_kind[seen] == EV_RELEASE);
        check_irq(test_name(exp_test[seen]), exp_vec, irq);
        check_status(test_name(exp_test[seen]), exp_status[seen], status);
        seen  = seen + 1;
        width = 1;
      end else if (irq != '0 && irq != prev_irq) begin
        stop_run("interrupt line changed without a low gap between pulses");
      end else if (irq != '0) begin
        width = width + 1;
      end else if (prev_irq != '0) begin
        check_width("pulse_width", `E300_IRQ_STRETCH, width);
      end
      prev_irq = irq;
    end
  end

endmodule

/* e300_button_irq.f */
+incdir+hdl
hdl/button_event_pkg.sv
hdl/irq_pkg.sv
hdl/button_edge_detect.sv
hdl/event_fifo.sv
hdl/irq_stretch.sv
hdl/e300_button_irq.sv
testbench/e300_button_irq_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the button interrupt testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f e300_button_irq.f \
  --top-module e300_button_irq_tb > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/Ve300_button_irq_tb > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1

/* testbench/button_irq_trace.txt */
# S level hold | T toggles hold | E test kind seq overflow
# kind 0 press 1 release, tests 2 press_release 4 glitch 5 burst_overflow
S 1 20
S 0 30
S 1 30
S 0 1
S 1 1
S 0 3
S 1 40
T 15 3
S 1 100
E 2 0 0 0
E 2 1 1 0
E 4 0 2 0
E 4 1 3 0
E 5 0 4 0
E 5 1 5 0
E 5 0 6 0
E 5 1 7 0
E 5 0 8 1
E 5 1 9 1
E 5 0 10 1
E 5 1 11 1
E 5 0 12 1
E 5 1 13 1
E 5 0 14 1
E 5 1 15 1
E 5 1 17 1
